/* hdl/noc_pkg.sv */
package noc_pkg;

	localparam int FLIT_WIDTH = 4;
	localparam int PACKET_WIDTH = 32;
	localparam int PACKET_FLITS = PACKET_WIDTH / FLIT_WIDTH;
	localparam int NUM_PORTS = 5;

	// port order used by every request, grant and full vector
	localparam int PORT_LOCAL = 0;
	localparam int PORT_NORTH = 1;
	localparam int PORT_SOUTH = 2;
	localparam int PORT_EAST = 3;
	localparam int PORT_WEST = 4;

	typedef logic [FLIT_WIDTH-1:0] flit_t;     // head flit is {dst_x, dst_y}
	typedef logic [1:0] coord_t;
	typedef logic [PACKET_WIDTH-1:0] packet_t; // msb nibble goes out first
	typedef logic [NUM_PORTS-1:0] port_vec_t;
	typedef logic [2:0] port_sel_t;
	typedef logic [2:0] flit_cnt_t;

	typedef struct packed {
		logic write;
		flit_t flit;
	} link_t;

	typedef enum logic {
		PS_HEAD,
		PS_BODY
	} port_state_t;

endpackage

/* hdl/flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo import noc_pkg::*; #(
	parameter int DEPTH = 8
) (
	input logic clk_local,
	input logic reset,
	input logic wr,
	input flit_t wr_flit,
	input logic rd,
	output flit_t rd_flit,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	flit_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr && !full; // flit dropped when full
	assign do_rd = rd && !empty;
	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign rd_flit = mem[rd_ptr];

	always_ff @(posedge clk_local)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk_local)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// input port must only pop a flit it has seen
	a_no_read_empty: assert property (@(posedge clk_local) disable iff (reset)
		rd |-> !empty);

endmodule

/* hdl/packet_serializer.sv */
`timescale 1ns/1ps

module packet_serializer import noc_pkg::*; (
	input logic clk_local,
	input logic reset,
	input logic wr,
	input packet_t packet,
	input logic rd,
	output flit_t flit,
	output logic empty,
	output logic full
);

	packet_t shift;
	flit_cnt_t idx;
	logic loaded;
	logic accept;

	assign accept = wr && !loaded; // a write while busy is lost
	assign flit = shift[PACKET_WIDTH-1 -: FLIT_WIDTH];
	assign empty = !loaded;
	assign full = loaded;

	always_ff @(posedge clk_local)
	begin
		if (accept)
			shift <= packet;
		else if (rd)
			shift <= shift << FLIT_WIDTH; // next nibble to the top
	end

	always_ff @(posedge clk_local)
	begin
		if (reset)
		begin
			loaded <= 1'b0;
			idx <= '0;
		end
		else if (accept)
		begin
			loaded <= 1'b1;
			idx <= '0;
		end
		else if (rd && loaded)
		begin
			idx <= idx + 1'b1;
			if (idx == flit_cnt_t'(PACKET_FLITS - 1))
				loaded <= 1'b0;
		end
	end

	a_no_read_empty: assert property (@(posedge clk_local) disable iff (reset)
		rd |-> !empty);

endmodule

/* hdl/input_port.sv */
`timescale 1ns/1ps

module input_port import noc_pkg::*; #(
	parameter coord_t X_COORD = 2'd1,
	parameter coord_t Y_COORD = 2'd1
) (
	input logic clk_local,
	input logic reset,
	input logic empty,
	input flit_t flit_in,
	input logic grant,
	output logic rd,
	output flit_t flit_out,
	output logic send,
	output port_vec_t request
);

	port_state_t state;
	port_vec_t dest;
	port_vec_t route;
	flit_cnt_t cnt;
	coord_t dst_x;
	coord_t dst_y;

	assign dst_x = flit_in[3:2];
	assign dst_y = flit_in[1:0];

	// xy dimension order, x first
	always_comb
	begin
		route = '0;
		if (dst_x > X_COORD)
			route[PORT_EAST] = 1'b1;
		else if (dst_x < X_COORD)
			route[PORT_WEST] = 1'b1;
		else if (dst_y > Y_COORD)
			route[PORT_NORTH] = 1'b1;
		else if (dst_y < Y_COORD)
			route[PORT_SOUTH] = 1'b1;
		else
			route[PORT_LOCAL] = 1'b1;
	end

	assign request = (state == PS_BODY) ? dest : '0;
	assign send = (state == PS_BODY) && grant && !empty;
	assign rd = send;
	assign flit_out = flit_in;

	always_ff @(posedge clk_local)
	begin
		if (state == PS_HEAD && !empty)
			dest <= route; // head stays in the source, sent as flit 0
	end

	always_ff @(posedge clk_local)
	begin
		if (reset)
		begin
			state <= PS_HEAD;
			cnt <= '0;
		end
		else
		begin
			case (state)
				PS_HEAD:
				begin
					cnt <= '0;
					if (!empty)
						state <= PS_BODY;
				end
				PS_BODY:
				begin
					if (send)
					begin
						cnt <= cnt + 1'b1;
						if (cnt == flit_cnt_t'(PACKET_FLITS - 1))
							state <= PS_HEAD; // tail gone, request drops
					end
				end
				default: state <= PS_HEAD;
			endcase
		end
	end

	a_request_onehot: assert property (@(posedge clk_local) disable iff (reset)
		$onehot0(request));

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter import noc_pkg::*; (
	input logic clk_local,
	input logic reset,
	input port_vec_t request,
	input logic dest_full,
	output port_vec_t grant,
	output port_sel_t select
);

	logic lock;
	port_sel_t owner;
	port_sel_t ptr;
	port_sel_t base;
	port_sel_t pick;
	logic pick_valid;
	logic owner_hold;

	function automatic port_sel_t next_port(input port_sel_t p);
		return (p == port_sel_t'(NUM_PORTS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign owner_hold = lock && request[owner];
	// owner just finished, so search already starts past it
	assign base = lock ? next_port(owner) : ptr;

	always_comb
	begin
		port_sel_t idx;
		idx = base;
		pick = owner;
		pick_valid = 1'b0;
		if (owner_hold)
			pick_valid = 1'b1;
		else
		begin
			for (int i = 0; i < NUM_PORTS; i++)
			begin
				if (!pick_valid && request[idx])
				begin
					pick = idx;
					pick_valid = 1'b1;
				end
				idx = next_port(idx);
			end
		end
	end

	assign grant = (pick_valid && !dest_full) ? port_vec_t'(1) << pick : '0;
	assign select = pick;

	always_ff @(posedge clk_local)
	begin
		if (reset)
		begin
			lock <= 1'b0;
			owner <= '0;
			ptr <= '0; // local first
		end
		else if (!dest_full) // stalled output keeps its lock and pointer
		begin
			if (lock && !request[owner])
				ptr <= next_port(owner);
			if (!owner_hold)
			begin
				lock <= pick_valid;
				if (pick_valid)
					owner <= pick;
			end
		end
	end

	a_grant_onehot: assert property (@(posedge clk_local) disable iff (reset)
		$onehot0(grant) && ((grant & ~request) == '0));

endmodule

/* hdl/crossbar.sv */
`timescale 1ns/1ps

module crossbar import noc_pkg::*; (
	input logic clk_local,
	input logic reset,
	input flit_t [NUM_PORTS-1:0] in_flit,
	input port_vec_t in_send,
	input port_sel_t [NUM_PORTS-1:0] sel,
	input port_vec_t sel_valid,
	output link_t [NUM_PORTS-1:0] out
);

	always_ff @(posedge clk_local)
	begin
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			if (reset)
				out[o].write <= 1'b0;
			else
				out[o].write <= sel_valid[o] && in_send[sel[o]];
			out[o].flit <= in_flit[sel[o]]; // only meaningful with write
		end
	end

endmodule

/* hdl/router.sv */
`timescale 1ns/1ps

module router import noc_pkg::*; #(
	parameter coord_t X_COORD = 2'd1,
	parameter coord_t Y_COORD = 2'd1,
	parameter int FIFO_DEPTH = 8
) (
	input logic clk_local,
	input logic reset,
	input packet_t local_in,
	input logic write_en_local,
	input link_t north_in,
	input link_t south_in,
	input link_t east_in,
	input link_t west_in,
	input logic local_neuron_full,
	input logic north_neighbor_full,
	input logic south_neighbor_full,
	input logic east_neighbor_full,
	input logic west_neighbor_full,
	output logic local_full,
	output logic north_full,
	output logic south_full,
	output logic east_full,
	output logic west_full,
	output link_t local_out,
	output link_t north_out,
	output link_t south_out,
	output link_t east_out,
	output link_t west_out
);

	port_vec_t src_empty;
	port_vec_t src_rd;
	flit_t [NUM_PORTS-1:0] src_flit;
	flit_t [NUM_PORTS-1:0] port_flit;
	port_vec_t port_send;
	port_vec_t port_grant;
	port_vec_t [NUM_PORTS-1:0] port_req;  // indexed by input
	port_vec_t [NUM_PORTS-1:0] arb_req;   // indexed by output
	port_vec_t [NUM_PORTS-1:0] arb_grant;
	port_sel_t [NUM_PORTS-1:0] arb_sel;
	port_vec_t arb_valid;
	port_vec_t dest_full;
	link_t [NUM_PORTS-1:1] nb_in;
	logic [NUM_PORTS-1:1] nb_full;
	link_t [NUM_PORTS-1:0] out_link;

	assign nb_in = {west_in, east_in, south_in, north_in};
	assign {west_full, east_full, south_full, north_full} = nb_full;
	assign dest_full = {west_neighbor_full, east_neighbor_full, south_neighbor_full,
		north_neighbor_full, local_neuron_full};
	assign {west_out, east_out, south_out, north_out, local_out} = out_link;

	packet_serializer local_ser_i (
		.clk_local(clk_local),
		.reset(reset),
		.wr(write_en_local),
		.packet(local_in),
		.rd(src_rd[PORT_LOCAL]),
		.flit(src_flit[PORT_LOCAL]),
		.empty(src_empty[PORT_LOCAL]),
		.full(local_full)
	);

	for (genvar j = 1; j < NUM_PORTS; j++)
	begin : g_fifo
		flit_fifo #(.DEPTH(FIFO_DEPTH)) fifo_i (
			.clk_local(clk_local),
			.reset(reset),
			.wr(nb_in[j].write),
			.wr_flit(nb_in[j].flit),
			.rd(src_rd[j]),
			.rd_flit(src_flit[j]),
			.empty(src_empty[j]),
			.full(nb_full[j])
		);
	end

	for (genvar j = 0; j < NUM_PORTS; j++)
	begin : g_port
		input_port #(.X_COORD(X_COORD), .Y_COORD(Y_COORD)) port_i (
			.clk_local(clk_local),
			.reset(reset),
			.empty(src_empty[j]),
			.flit_in(src_flit[j]),
			.grant(port_grant[j]),
			.rd(src_rd[j]),
			.flit_out(port_flit[j]),
			.send(port_send[j]),
			.request(port_req[j])
		);
	end

	// requests transposed to the arbiters, grants folded back per input
	always_comb
	begin
		for (int j = 0; j < NUM_PORTS; j++)
		begin
			port_grant[j] = 1'b0;
			for (int k = 0; k < NUM_PORTS; k++)
			begin
				arb_req[k][j] = port_req[j][k];
				port_grant[j] = port_grant[j] | arb_grant[k][j];
			end
		end
	end

	for (genvar k = 0; k < NUM_PORTS; k++)
	begin : g_arb
		rr_arbiter arb_i (
			.clk_local(clk_local),
			.reset(reset),
			.request(arb_req[k]),
			.dest_full(dest_full[k]),
			.grant(arb_grant[k]),
			.select(arb_sel[k])
		);
		assign arb_valid[k] = |arb_grant[k];
	end

	crossbar xbar_i (
		.clk_local(clk_local),
		.reset(reset),
		.in_flit(port_flit),
		.in_send(port_send),
		.sel(arb_sel),
		.sel_valid(arb_valid),
		.out(out_link)
	);

endmodule

/* verif/router_tb.sv */
`timescale 1ns/1ps

module router_tb import noc_pkg::*; ();

	localparam int TB_X = 1;
	localparam int TB_Y = 1;
	localparam int TIMEOUT = 400;
	localparam int DRAIN_LIMIT = 4000;

	logic clk_local;
	logic reset;
	packet_t local_in;
	logic write_en_local;
	link_t in_link [NUM_PORTS]; // entry 0 unused, local has its own packet input
	logic dest_full [NUM_PORTS];
	logic src_full [NUM_PORTS];
	link_t out_link [NUM_PORTS];

	packet_t exp_q [NUM_PORTS*NUM_PORTS][$]; // output * 5 + source
	packet_t got_q [NUM_PORTS][$];
	packet_t src_q [NUM_PORTS][$];
	packet_t asm_pkt [NUM_PORTS];
	int asm_cnt [NUM_PORTS];
	int flits_seen [NUM_PORTS];
	int head_cycle [NUM_PORTS];
	int cycle = 0;
	int outstanding;
	int errors;
	int test_start_errors;
	int tests_passed;
	int tests_failed;
	integer seed;
	string port_name [NUM_PORTS] = '{"local", "north", "south", "east", "west"};

	router #(
		.X_COORD(2'(TB_X)),
		.Y_COORD(2'(TB_Y)),
		.FIFO_DEPTH(8)
	) dut_i (
		.clk_local(clk_local),
		.reset(reset),
		.local_in(local_in),
		.write_en_local(write_en_local),
		.north_in(in_link[PORT_NORTH]),
		.south_in(in_link[PORT_SOUTH]),
		.east_in(in_link[PORT_EAST]),
		.west_in(in_link[PORT_WEST]),
		.local_neuron_full(dest_full[PORT_LOCAL]),
		.north_neighbor_full(dest_full[PORT_NORTH]),
		.south_neighbor_full(dest_full[PORT_SOUTH]),
		.east_neighbor_full(dest_full[PORT_EAST]),
		.west_neighbor_full(dest_full[PORT_WEST]),
		.local_full(src_full[PORT_LOCAL]),
		.north_full(src_full[PORT_NORTH]),
		.south_full(src_full[PORT_SOUTH]),
		.east_full(src_full[PORT_EAST]),
		.west_full(src_full[PORT_WEST]),
		.local_out(out_link[PORT_LOCAL]),
		.north_out(out_link[PORT_NORTH]),
		.south_out(out_link[PORT_SOUTH]),
		.east_out(out_link[PORT_EAST]),
		.west_out(out_link[PORT_WEST])
	);

	initial
	begin
		clk_local = 1'b0;
		forever #10 clk_local = ~clk_local;
	end

	always @(posedge clk_local)
		cycle <= cycle + 1;

	// xy rule, x first, for a router sitting at (TB_X, TB_Y)
	function automatic int expected_port(input flit_t head);
		int dx;
		int dy;
		dx = int'(head[3:2]);
		dy = int'(head[1:0]);
		if (dx > TB_X)
			return PORT_EAST;
		if (dx < TB_X)
			return PORT_WEST;
		if (dy > TB_Y)
			return PORT_NORTH;
		if (dy < TB_Y)
			return PORT_SOUTH;
		return PORT_LOCAL;
	endfunction

	// outputs are registered, so sample them away from the rising edge
	always @(negedge clk_local)
	begin
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			if (!reset && out_link[o].write)
			begin
				if (asm_cnt[o] == 0)
					head_cycle[o] = cycle;
				asm_pkt[o] = {asm_pkt[o][PACKET_WIDTH-FLIT_WIDTH-1:0], out_link[o].flit};
				asm_cnt[o]++;
				flits_seen[o]++;
				if (asm_cnt[o] == PACKET_FLITS)
				begin
					got_q[o].push_back(asm_pkt[o]); // eight flits in a row
					asm_cnt[o] = 0;
				end
			end
		end
	end

	// a packet must match the oldest outstanding one of some source
	always @(posedge clk_local)
	begin
		packet_t got;
		int hit;
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			while (got_q[o].size() > 0)
			begin
				got = got_q[o].pop_front();
				hit = -1;
				for (int s = 0; s < NUM_PORTS; s++)
				begin
					if (hit < 0 && exp_q[o*NUM_PORTS+s].size() > 0
						&& exp_q[o*NUM_PORTS+s][0] == got)
						hit = s;
				end
				assert (hit >= 0)
				else
				begin
					$display("** Error %s_out: got packet %h, matching no expected packet",
						port_name[o], got);
					errors++;
				end
				if (hit >= 0)
				begin
					void'(exp_q[o*NUM_PORTS+hit].pop_front());
					outstanding--;
				end
			end
		end
	end

	task automatic tick();
		@(posedge clk_local);
		#2;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic wait_source_free(input int s);
		int n;
		n = 0;
		while (src_full[s])
		begin
			if (s != PORT_LOCAL)
				in_link[s].write = 1'b0;
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run($sformatf("timeout: %s input stayed full", port_name[s]));
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (outstanding > 0)
		begin
			tick();
			n++;
			if (n > DRAIN_LIMIT)
				abort_run($sformatf("timeout: %0d packets never arrived", outstanding));
		end
	endtask

	task automatic push_expected(input int s, input packet_t p);
		exp_q[expected_port(p[31:28])*NUM_PORTS + s].push_back(p);
		outstanding++;
	endtask

	task automatic send_local(input packet_t p, output int edge_no);
		wait_source_free(PORT_LOCAL);
		push_expected(PORT_LOCAL, p);
		local_in = p;
		write_en_local = 1'b1;
		edge_no = cycle + 1; // edge that takes the packet
		tick();
		write_en_local = 1'b0;
	endtask

	task automatic send_neighbour(input int s, input packet_t p);
		push_expected(s, p);
		for (int i = PACKET_FLITS - 1; i >= 0; i--)
		begin
			wait_source_free(s);
			in_link[s].write = 1'b1;
			in_link[s].flit = p[i*FLIT_WIDTH +: FLIT_WIDTH];
			tick();
		end
		in_link[s].write = 1'b0;
	endtask

	task automatic send_all(input int s);
		packet_t p;
		int e;
		while (src_q[s].size() > 0)
		begin
			p = src_q[s].pop_front();
			if (s == PORT_LOCAL)
				send_local(p, e);
			else
				send_neighbour(s, p);
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors)
			tests_passed++;
		else
			tests_failed++;
		$display("test %-18s %s", name, (errors == test_start_errors) ? "ok" : "failed");
		test_start_errors = errors;
	endtask

	initial
	begin
		flit_t heads [5];
		packet_t p;
		int w;
		int o;
		int east_before;
		seed = 21;
		reset = 1'b1;
		local_in = '0;
		write_en_local = 1'b0;
		outstanding = 0;
		errors = 0;
		test_start_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < NUM_PORTS; i++)
		begin
			in_link[i] = '0;
			dest_full[i] = 1'b0;
			asm_pkt[i] = '0;
			asm_cnt[i] = 0;
			flits_seen[i] = 0;
			head_cycle[i] = 0;
		end
		repeat (8) @(posedge clk_local);
		#2;
		reset = 1'b0;
		tick();

		for (int i = 0; i < NUM_PORTS; i++)
		begin
			assert (!out_link[i].write && !src_full[i])
			else
			begin
				$display("** Error %s after reset: write %h, full %h, expected 0",
					port_name[i], out_link[i].write, src_full[i]);
				errors++;
			end
		end
		end_test("reset");

		heads = '{4'h9, 4'h1, 4'h6, 4'h4, 4'h5}; // (2,1) (0,1) (1,2) (1,0) (1,1)
		for (int i = 0; i < 5; i++)
		begin
			p = {heads[i], 28'h0abcdef + 28'(i)};
			send_local(p, w);
			wait_drain();
			o = expected_port(heads[i]);
			assert (head_cycle[o] - w == 2)
			else
			begin
				$display("** Error %s_out head latency: got %h, expected %h",
					port_name[o], head_cycle[o] - w, 2);
				errors++;
			end
		end
		end_test("local routing");

		send_neighbour(PORT_WEST, 32'hd1e2f3a4);  // (3,1) goes east
		send_neighbour(PORT_NORTH, 32'h5a5a0f0f); // (1,1) stays local
		wait_drain();
		end_test("neighbour transit");

		fork
			send_neighbour(PORT_NORTH, 32'he0000001);
			send_neighbour(PORT_SOUTH, 32'heffffff2);
		join
		wait_drain();
		end_test("contention");

		dest_full[PORT_EAST] = 1'b1;
		east_before = flits_seen[PORT_EAST];
		send_local(32'h9c3c3c3c, w);
		repeat (20) tick();
		assert (flits_seen[PORT_EAST] == east_before)
		else
		begin
			$display("** Error east_out.write while held: got %h flits, expected %h",
				flits_seen[PORT_EAST] - east_before, 0);
			errors++;
		end
		dest_full[PORT_EAST] = 1'b0;
		wait_drain();
		end_test("back-pressure");

		send_local(32'h1badf00d, w);
		assert (src_full[PORT_LOCAL])
		else
		begin
			$display("** Error local_full: got %h, expected %h", src_full[PORT_LOCAL], 1);
			errors++;
		end
		local_in = 32'h6deadbee; // must be ignored
		write_en_local = 1'b1;
		tick();
		write_en_local = 1'b0;
		wait_drain();
		repeat (12) tick();
		assert (!src_full[PORT_LOCAL])
		else
		begin
			$display("** Error local_full after drain: got %h, expected %h",
				src_full[PORT_LOCAL], 0);
			errors++;
		end
		end_test("local full");

		for (int i = 0; i < 40; i++)
		begin
			o = int'($unsigned($random(seed)) % NUM_PORTS);
			p = $random(seed);
			src_q[o].push_back(p);
		end
		fork
			send_all(PORT_LOCAL);
			send_all(PORT_NORTH);
			send_all(PORT_SOUTH);
			send_all(PORT_EAST);
			send_all(PORT_WEST);
		join
		wait_drain();
		end_test("random traffic");

		$display("tests: %0d ok, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* verilog.f */
hdl/noc_pkg.sv
hdl/flit_fifo.sv
hdl/packet_serializer.sv
hdl/input_port.sv
hdl/rr_arbiter.sv
hdl/crossbar.sv
hdl/router.sv
verif/router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the router testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module router_tb \
	-f verilog.f -o router_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/router_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "PASS: all tests" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
